/* design/mshr_pkg.sv */
package mshr_pkg;

  // line address width
  localparam int ADDR_W = 32;

  // one cache line of data
  localparam int LINE_W = 64;

  // memory transaction tag, 0 means no response
  localparam int TAG_W = 4;

  // misses the cache can hand over per cycle
  localparam int MISS_PORTS = 3;

  // command toward memory
  typedef enum logic [1:0] {
    BUS_NONE  = 2'd0,
    BUS_LOAD  = 2'd1,
    BUS_STORE = 2'd2
  } mem_cmd_e;

  // progress of one outstanding transaction
  // waiting: not yet sent
  // inprogress: accepted, tag held
  // done: data back (load) or accepted (store)
  typedef enum logic [1:0] {
    WAITING    = 2'd0,
    INPROGRESS = 2'd1,
    DONE       = 2'd2
  } entry_state_e;

endpackage

/* design/mshr_alloc.sv */
`timescale 1ns/100ps

module mshr_alloc import mshr_pkg::*; #(
  parameter int DEPTH = 8
) (
  input  logic                                  clock,
  input  logic                                  reset,
  input  logic     [MISS_PORTS-1:0]             miss_en,
  input  logic     [MISS_PORTS-1:0][ADDR_W-1:0] miss_addr,
  input  logic     [MISS_PORTS-1:0][LINE_W-1:0] miss_data,
  input  mem_cmd_e [MISS_PORTS-1:0]             miss_cmd,
  input  logic     [MISS_PORTS-1:0]             miss_dirty,
  input  logic     [DEPTH-1:0]                  entry_valid,
  output logic                                  mshr_ready,
  output logic     [DEPTH-1:0]                  slot_we,
  output logic     [DEPTH-1:0][ADDR_W-1:0]      slot_addr,
  output logic     [DEPTH-1:0][LINE_W-1:0]      slot_data,
  output mem_cmd_e [DEPTH-1:0]                  slot_cmd,
  output logic     [DEPTH-1:0]                  slot_dirty
);

  localparam int PTR_W = $clog2(DEPTH);

  logic [PTR_W-1:0] tail;
  logic [PTR_W-1:0] tail_p1;
  logic [PTR_W-1:0] tail_p2;
  logic [MISS_PORTS-1:0] take;
  // running count of packed ports, final value is the tail step
  logic [PTR_W-1:0] fill_cnt;
  logic [PTR_W-1:0] slot_idx;

  assign tail_p1 = tail + 1'b1;
  assign tail_p2 = tail + 2'd2;

  // room for a full burst of three from the tail on
  assign mshr_ready = ~entry_valid[tail] & ~entry_valid[tail_p1] & ~entry_valid[tail_p2];

  // requester holds and retries while not ready
  assign take = miss_en & {MISS_PORTS{mshr_ready}};

  always_comb begin
    slot_we    = '0;
    slot_addr  = '0;
    slot_data  = '0;
    slot_dirty = '0;
    for (int i = 0; i < DEPTH; i++) begin
      slot_cmd[i] = BUS_NONE;
    end
    fill_cnt = '0;
    slot_idx = tail;
    // enabled ports land in port order, no gaps
    for (int p = 0; p < MISS_PORTS; p++) begin
      if (take[p]) begin
        slot_idx = tail + fill_cnt;
        slot_we[slot_idx]    = 1'b1;
        slot_addr[slot_idx]  = miss_addr[p];
        slot_data[slot_idx]  = miss_data[p];
        slot_cmd[slot_idx]   = miss_cmd[p];
        slot_dirty[slot_idx] = miss_dirty[p];
        fill_cnt = fill_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      tail <= '0;
    end else begin
      tail <= tail + fill_cnt;
    end
  end

endmodule

/* design/mshr_entries.sv */
`timescale 1ns/100ps

module mshr_entries import mshr_pkg::*; #(
  parameter int DEPTH = 8
) (
  input  logic                              clock,
  input  logic                              reset,
  // allocation
  input  logic         [DEPTH-1:0]             slot_we,
  input  logic         [DEPTH-1:0][ADDR_W-1:0] slot_addr,
  input  logic         [DEPTH-1:0][LINE_W-1:0] slot_data,
  input  mem_cmd_e     [DEPTH-1:0]             slot_cmd,
  input  logic         [DEPTH-1:0]             slot_dirty,
  // issue and memory reply
  input  logic         [$clog2(DEPTH)-1:0]     issue_idx,
  input  logic                                 issue_accept,
  input  logic         [TAG_W-1:0]             mem2proc_response,
  input  logic         [TAG_W-1:0]             mem2proc_tag,
  input  logic         [LINE_W-1:0]            mem2proc_data,
  // writeback
  input  logic         [$clog2(DEPTH)-1:0]     retire_idx,
  input  logic                                 retire_fire,
  // store merge
  input  logic                                 merge_en,
  input  logic         [$clog2(DEPTH)-1:0]     merge_idx,
  input  logic         [LINE_W-1:0]            store_search_data,
  output logic         [DEPTH-1:0]             entry_valid,
  output logic         [DEPTH-1:0][ADDR_W-1:0] entry_addr,
  output logic         [DEPTH-1:0][LINE_W-1:0] entry_data,
  output mem_cmd_e     [DEPTH-1:0]             entry_cmd,
  output entry_state_e [DEPTH-1:0]             entry_state,
  output logic         [DEPTH-1:0]             entry_dirty,
  output logic                                 mshr_empty
);

  localparam int PTR_W = $clog2(DEPTH);

  // tag handed out by memory on acceptance
  logic [DEPTH-1:0][TAG_W-1:0] entry_tag;

  // per-entry event decode
  logic [DEPTH-1:0] accept_hit;
  logic [DEPTH-1:0] tag_hit;
  logic [DEPTH-1:0] merge_hit;
  logic [DEPTH-1:0] retire_hit;

  always_comb begin
    for (int i = 0; i < DEPTH; i++) begin
      accept_hit[i] = issue_accept && (issue_idx == PTR_W'(i));
      retire_hit[i] = retire_fire && (retire_idx == PTR_W'(i));
      merge_hit[i]  = merge_en && (merge_idx == PTR_W'(i));
      // tag 0 is the idle value on the reply bus
      tag_hit[i] = entry_valid[i] && (entry_state[i] == INPROGRESS) &&
                   (entry_cmd[i] == BUS_LOAD) && (mem2proc_tag != '0) &&
                   (mem2proc_tag == entry_tag[i]);
    end
  end

  // valid and progress
  always_ff @(posedge clock) begin
    for (int i = 0; i < DEPTH; i++) begin
      if (reset) begin
        entry_valid[i] <= 1'b0;
        entry_state[i] <= WAITING;
      end else if (slot_we[i]) begin
        entry_valid[i] <= 1'b1;
        entry_state[i] <= WAITING;
      end else begin
        if (retire_hit[i]) begin
          entry_valid[i] <= 1'b0;
        end
        if (tag_hit[i]) begin
          entry_state[i] <= DONE;
        end else if (accept_hit[i]) begin
          // a store needs no reply, accepted means finished
          entry_state[i] <= (entry_cmd[i] == BUS_STORE) ? DONE : INPROGRESS;
        end
      end
    end
  end

  // line payload, command and tag
  always_ff @(posedge clock) begin
    for (int i = 0; i < DEPTH; i++) begin
      if (slot_we[i]) begin
        entry_addr[i]  <= slot_addr[i];
        entry_data[i]  <= slot_data[i];
        entry_cmd[i]   <= slot_cmd[i];
        entry_dirty[i] <= slot_dirty[i];
      end else begin
        if (tag_hit[i]) begin
          // fresh line from memory is clean
          entry_data[i]  <= mem2proc_data;
          entry_dirty[i] <= 1'b0;
        end else if (merge_hit[i]) begin
          entry_data[i] <= store_search_data;
          // store into a filled line makes it dirty
          if (entry_cmd[i] == BUS_LOAD) begin
            entry_dirty[i] <= 1'b1;
          end
        end
        if (accept_hit[i]) begin
          entry_tag[i] <= mem2proc_response;
        end
      end
    end
  end

  assign mshr_empty = ~|entry_valid;

endmodule

/* design/mshr_issue.sv */
`timescale 1ns/100ps

module mshr_issue import mshr_pkg::*; #(
  parameter int DEPTH = 8
) (
  input  logic                                 clock,
  input  logic                                 reset,
  input  logic         [DEPTH-1:0]             entry_valid,
  input  entry_state_e [DEPTH-1:0]             entry_state,
  input  mem_cmd_e     [DEPTH-1:0]             entry_cmd,
  input  logic         [DEPTH-1:0][ADDR_W-1:0] entry_addr,
  input  logic         [DEPTH-1:0][LINE_W-1:0] entry_data,
  input  logic         [TAG_W-1:0]             mem2proc_response,
  output mem_cmd_e                             proc2mem_command,
  output logic         [ADDR_W-1:0]            proc2mem_addr,
  output logic         [LINE_W-1:0]            proc2mem_data,
  output logic         [$clog2(DEPTH)-1:0]     issue_idx,
  output logic                                 issue_accept
);

  localparam int PTR_W = $clog2(DEPTH);

  logic [PTR_W-1:0] head;
  logic             head_pending;

  // head entry still owes memory a request
  assign head_pending = entry_valid[head] && (entry_state[head] == WAITING);

  assign proc2mem_command = head_pending ? entry_cmd[head] : BUS_NONE;
  assign proc2mem_addr    = entry_addr[head];
  assign proc2mem_data    = entry_data[head];

  // nonzero response is both the accept and the tag
  assign issue_accept = head_pending && (mem2proc_response != '0);
  assign issue_idx    = head;

  always_ff @(posedge clock) begin
    if (reset) begin
      head <= '0;
    end else if (issue_accept) begin
      head <= head + 1'b1;
    end
  end

endmodule

/* design/mshr_retire.sv */
`timescale 1ns/100ps

module mshr_retire import mshr_pkg::*; #(
  parameter int DEPTH = 8
) (
  input  logic                                 clock,
  input  logic                                 reset,
  input  logic         [DEPTH-1:0]             entry_valid,
  input  entry_state_e [DEPTH-1:0]             entry_state,
  input  mem_cmd_e     [DEPTH-1:0]             entry_cmd,
  input  logic         [DEPTH-1:0][ADDR_W-1:0] entry_addr,
  input  logic         [DEPTH-1:0][LINE_W-1:0] entry_data,
  input  logic         [DEPTH-1:0]             entry_dirty,
  input  logic                                 stored_mem_wr,
  output logic                                 mem_wr,
  output logic         [ADDR_W-1:0]            mem_addr,
  output logic         [LINE_W-1:0]            mem_data,
  output logic                                 mem_dirty,
  output logic         [$clog2(DEPTH)-1:0]     retire_idx,
  output logic                                 retire_fire
);

  localparam int PTR_W = $clog2(DEPTH);

  logic [PTR_W-1:0] wb_head;
  logic             head_done;
  logic             head_is_load;

  assign head_done    = entry_valid[wb_head] && (entry_state[wb_head] == DONE);
  assign head_is_load = (entry_cmd[wb_head] == BUS_LOAD);

  // only filled loads go back to the cache
  assign mem_wr    = head_done && head_is_load;
  assign mem_addr  = entry_addr[wb_head];
  assign mem_data  = entry_data[wb_head];
  assign mem_dirty = entry_dirty[wb_head];

  // evicted store leaves once memory has taken it
  assign retire_fire = head_done && (head_is_load ? stored_mem_wr : 1'b1);
  assign retire_idx  = wb_head;

  always_ff @(posedge clock) begin
    if (reset) begin
      wb_head <= '0;
    end else if (retire_fire) begin
      wb_head <= wb_head + 1'b1;
    end
  end

endmodule

/* design/mshr_search.sv */
`timescale 1ns/100ps

module mshr_search import mshr_pkg::*; #(
  parameter int DEPTH = 8
) (
  input  logic         [$clog2(DEPTH)-1:0]     retire_idx,
  input  logic         [DEPTH-1:0]             entry_valid,
  input  logic         [DEPTH-1:0][ADDR_W-1:0] entry_addr,
  input  mem_cmd_e     [DEPTH-1:0]             entry_cmd,
  input  entry_state_e [DEPTH-1:0]             entry_state,
  input  logic                                 store_search_en,
  input  logic         [ADDR_W-1:0]            store_search_addr,
  output logic                                 store_hit,
  output logic                                 merge_en,
  output logic         [$clog2(DEPTH)-1:0]     merge_idx
);

  localparam int PTR_W = $clog2(DEPTH);

  logic             found;
  logic [PTR_W-1:0] scan_idx;
  logic             mergeable;

  // oldest first, starting at the writeback head
  always_comb begin
    found     = 1'b0;
    merge_idx = retire_idx;
    scan_idx  = retire_idx;
    mergeable = 1'b0;
    for (int k = 0; k < DEPTH; k++) begin
      scan_idx = retire_idx + PTR_W'(k);
      // store not yet sent, or load already filled
      // a load still in flight would lose the data to the fill
      mergeable = ((entry_cmd[scan_idx] == BUS_STORE) && (entry_state[scan_idx] == WAITING)) ||
                  ((entry_cmd[scan_idx] == BUS_LOAD) && (entry_state[scan_idx] == DONE));
      if (!found && entry_valid[scan_idx] && mergeable &&
          (entry_addr[scan_idx] == store_search_addr)) begin
        found     = 1'b1;
        merge_idx = scan_idx;
      end
    end
  end

  assign store_hit = store_search_en && found;

  // hit always writes the line
  assign merge_en = store_hit;

endmodule

/* design/mshr_top.sv */
`timescale 1ns/100ps

module mshr_top import mshr_pkg::*; #(
  parameter int DEPTH = 8
) (
  input  logic                                  clock,
  input  logic                                  reset,
  // misses from the cache
  input  logic     [MISS_PORTS-1:0]             miss_en,
  input  logic     [MISS_PORTS-1:0][ADDR_W-1:0] miss_addr,
  input  logic     [MISS_PORTS-1:0][LINE_W-1:0] miss_data,
  input  mem_cmd_e [MISS_PORTS-1:0]             miss_cmd,
  input  logic     [MISS_PORTS-1:0]             miss_dirty,
  // store lookup
  input  logic                                  store_search_en,
  input  logic     [ADDR_W-1:0]                 store_search_addr,
  input  logic     [LINE_W-1:0]                 store_search_data,
  output logic                                  store_hit,
  // memory side
  output mem_cmd_e                              proc2mem_command,
  output logic     [ADDR_W-1:0]                 proc2mem_addr,
  output logic     [LINE_W-1:0]                 proc2mem_data,
  input  logic     [TAG_W-1:0]                  mem2proc_response,
  input  logic     [TAG_W-1:0]                  mem2proc_tag,
  input  logic     [LINE_W-1:0]                 mem2proc_data,
  // fills back to the cache
  output logic                                  mem_wr,
  output logic     [ADDR_W-1:0]                 mem_addr,
  output logic     [LINE_W-1:0]                 mem_data,
  output logic                                  mem_dirty,
  input  logic                                  stored_mem_wr,
  output logic                                  mshr_ready,
  output logic                                  mshr_empty
);

  localparam int PTR_W = $clog2(DEPTH);

  logic         [DEPTH-1:0]             entry_valid;
  logic         [DEPTH-1:0][ADDR_W-1:0] entry_addr;
  logic         [DEPTH-1:0][LINE_W-1:0] entry_data;
  mem_cmd_e     [DEPTH-1:0]             entry_cmd;
  entry_state_e [DEPTH-1:0]             entry_state;
  logic         [DEPTH-1:0]             entry_dirty;

  logic     [DEPTH-1:0]             slot_we;
  logic     [DEPTH-1:0][ADDR_W-1:0] slot_addr;
  logic     [DEPTH-1:0][LINE_W-1:0] slot_data;
  mem_cmd_e [DEPTH-1:0]             slot_cmd;
  logic     [DEPTH-1:0]             slot_dirty;

  logic [PTR_W-1:0] issue_idx;
  logic             issue_accept;
  logic [PTR_W-1:0] retire_idx;
  logic             retire_fire;
  logic [PTR_W-1:0] merge_idx;
  logic             merge_en;

  mshr_alloc #(.DEPTH(DEPTH)) i_alloc (
    .clock, .reset,
    .miss_en, .miss_addr, .miss_data, .miss_cmd, .miss_dirty,
    .entry_valid, .mshr_ready,
    .slot_we, .slot_addr, .slot_data, .slot_cmd, .slot_dirty
  );

  mshr_entries #(.DEPTH(DEPTH)) i_entries (
    .clock, .reset,
    .slot_we, .slot_addr, .slot_data, .slot_cmd, .slot_dirty,
    .issue_idx, .issue_accept, .mem2proc_response, .mem2proc_tag, .mem2proc_data,
    .retire_idx, .retire_fire, .merge_en, .merge_idx, .store_search_data,
    .entry_valid, .entry_addr, .entry_data, .entry_cmd, .entry_state, .entry_dirty,
    .mshr_empty
  );

  mshr_issue #(.DEPTH(DEPTH)) i_issue (
    .clock, .reset,
    .entry_valid, .entry_state, .entry_cmd, .entry_addr, .entry_data,
    .mem2proc_response,
    .proc2mem_command, .proc2mem_addr, .proc2mem_data, .issue_idx, .issue_accept
  );

  mshr_retire #(.DEPTH(DEPTH)) i_retire (
    .clock, .reset,
    .entry_valid, .entry_state, .entry_cmd, .entry_addr, .entry_data, .entry_dirty,
    .stored_mem_wr,
    .mem_wr, .mem_addr, .mem_data, .mem_dirty, .retire_idx, .retire_fire
  );

  mshr_search #(.DEPTH(DEPTH)) i_search (
    .retire_idx, .entry_valid, .entry_addr, .entry_cmd, .entry_state,
    .store_search_en, .store_search_addr,
    .store_hit, .merge_en, .merge_idx
  );

endmodule

/* sim/tb_clock.sv */
`timescale 1ns/100ps

module tb_clock #(
  parameter real PERIOD = 4.0
) (
  output logic clock
);

  // free running, starts low
  initial begin
    clock = 1'b0;
    forever #(PERIOD / 2.0) clock = ~clock;
  end

endmodule

/* sim/mshr_chk.sv */
`timescale 1ns/100ps

module mshr_chk import mshr_pkg::*; (
  input logic     clock,
  input logic     reset,
  input logic     store_search_en,
  input logic     store_hit,
  input logic     mem_wr,
  input logic     mshr_empty,
  input mem_cmd_e proc2mem_command
);

  // failed assertions so far
  int fail_count = 0;

  // a hit only answers an active lookup
  a_hit_needs_lookup: assert property (@(posedge clock) disable iff (reset)
    store_hit |-> store_search_en)
    else begin
      $error("store_hit raised without store_search_en");
      fail_count++;
    end

  // a fill always comes from a live entry
  a_fill_not_empty: assert property (@(posedge clock) disable iff (reset)
    mem_wr |-> !mshr_empty)
    else begin
      $error("mem_wr raised while mshr_empty");
      fail_count++;
    end

  // nothing to send when no entry is held
  a_idle_when_empty: assert property (@(posedge clock) disable iff (reset)
    mshr_empty |-> (proc2mem_command == BUS_NONE))
    else begin
      $error("memory request while mshr_empty");
      fail_count++;
    end

endmodule

bind mshr_top mshr_chk i_chk (
  .clock, .reset, .store_search_en, .store_hit, .mem_wr, .mshr_empty, .proc2mem_command
);

/* sim/mshr_tb.sv */
`timescale 1ns/100ps

module mshr_tb import mshr_pkg::*; ();

  localparam int DEPTH = 8;
  // cycles any single wait may take
  localparam int TIMEOUT = 200;

  logic                              clock;
  logic                              reset;
  logic     [MISS_PORTS-1:0]             miss_en;
  logic     [MISS_PORTS-1:0][ADDR_W-1:0] miss_addr;
  logic     [MISS_PORTS-1:0][LINE_W-1:0] miss_data;
  mem_cmd_e [MISS_PORTS-1:0]             miss_cmd;
  logic     [MISS_PORTS-1:0]             miss_dirty;
  logic                              store_search_en;
  logic     [ADDR_W-1:0]             store_search_addr;
  logic     [LINE_W-1:0]             store_search_data;
  logic                              store_hit;
  mem_cmd_e                          proc2mem_command;
  logic     [ADDR_W-1:0]             proc2mem_addr;
  logic     [LINE_W-1:0]             proc2mem_data;
  logic     [TAG_W-1:0]              mem2proc_response;
  logic     [TAG_W-1:0]              mem2proc_tag;
  logic     [LINE_W-1:0]             mem2proc_data;
  logic                              mem_wr;
  logic     [ADDR_W-1:0]             mem_addr;
  logic     [LINE_W-1:0]             mem_data;
  logic                              mem_dirty;
  logic                              stored_mem_wr;
  logic                              mshr_ready;
  logic                              mshr_empty;

  int    error_count;
  int    tests_run;
  int    tests_failed;
  // error count when the current test started
  int    errors_at_start;
  string test_name;

  tb_clock #(.PERIOD(4.0)) i_clock (.clock);

  mshr_top #(.DEPTH(DEPTH)) i_dut (.*);

  task automatic report_value(input string what, input logic [63:0] expected,
                              input logic [63:0] actual);
    $display("Error: %s %s expected %h actual %h", test_name, what, expected, actual);
    error_count++;
  endtask

  task automatic report_fault(input string what);
    $display("%s: %s", test_name, what);
    error_count++;
  endtask

  task automatic start_test(input string name);
    test_name = name;
    errors_at_start = error_count;
    tests_run++;
  endtask

  task automatic finish_test();
    if (error_count != errors_at_start) begin
      tests_failed++;
      $display("test %s failed, %0d errors", test_name, error_count - errors_at_start);
    end else begin
      $display("test %s ok", test_name);
    end
  endtask

  // one miss cycle once the DUT has room
  // same command on every port
  task automatic allocate(input logic [MISS_PORTS-1:0] en,
                          input logic [MISS_PORTS-1:0][ADDR_W-1:0] addr,
                          input logic [MISS_PORTS-1:0][LINE_W-1:0] data,
                          input mem_cmd_e cmd, input logic [MISS_PORTS-1:0] dirty);
    int n;
    n = 0;
    @(negedge clock);
    while (!mshr_ready && n < TIMEOUT) begin
      @(negedge clock);
      n++;
    end
    if (!mshr_ready) report_fault("mshr_ready stayed low, miss could not be placed");
    @(posedge clock);
    miss_en    <= en;
    miss_addr  <= addr;
    miss_data  <= data;
    miss_dirty <= dirty;
    for (int p = 0; p < MISS_PORTS; p++) begin
      miss_cmd[p] <= cmd;
    end
    @(posedge clock);
    miss_en <= '0;
  endtask

  // memory model accepting the pending request with a chosen tag
  task automatic accept_request(input logic [TAG_W-1:0] tag, input mem_cmd_e cmd,
                                input logic [ADDR_W-1:0] addr,
                                input logic [LINE_W-1:0] data, input logic check_data);
    int n;
    n = 0;
    @(negedge clock);
    while (proc2mem_command == BUS_NONE && n < TIMEOUT) begin
      @(negedge clock);
      n++;
    end
    if (proc2mem_command == BUS_NONE) begin
      report_fault("timed out waiting for a memory request");
    end else begin
      if (proc2mem_command !== cmd) report_value("proc2mem_command", cmd, proc2mem_command);
      if (proc2mem_addr !== addr) report_value("proc2mem_addr", addr, proc2mem_addr);
      if (check_data && proc2mem_data !== data) report_value("proc2mem_data", data, proc2mem_data);
    end
    @(posedge clock);
    mem2proc_response <= tag;
    @(posedge clock);
    mem2proc_response <= '0;
  endtask

  // memory model returning one data beat on a tag
  task automatic send_reply(input logic [TAG_W-1:0] tag, input logic [LINE_W-1:0] data);
    @(posedge clock);
    mem2proc_tag  <= tag;
    mem2proc_data <= data;
    @(posedge clock);
    mem2proc_tag <= '0;
  endtask

  // cache side check of the fill before the strobe
  task automatic take_fill(input logic [ADDR_W-1:0] addr, input logic [LINE_W-1:0] data,
                           input logic dirty);
    int n;
    n = 0;
    @(negedge clock);
    while (!mem_wr && n < TIMEOUT) begin
      @(negedge clock);
      n++;
    end
    if (!mem_wr) begin
      report_fault("timed out waiting for mem_wr");
    end else begin
      if (mem_addr !== addr) report_value("mem_addr", addr, mem_addr);
      if (mem_data !== data) report_value("mem_data", data, mem_data);
      if (mem_dirty !== dirty) report_value("mem_dirty", dirty, mem_dirty);
    end
    @(posedge clock);
    stored_mem_wr <= 1'b1;
    @(posedge clock);
    stored_mem_wr <= 1'b0;
  endtask

  task automatic store_lookup(input logic [ADDR_W-1:0] addr, input logic [LINE_W-1:0] data,
                              input logic expect_hit);
    @(posedge clock);
    store_search_en   <= 1'b1;
    store_search_addr <= addr;
    store_search_data <= data;
    @(negedge clock);
    if (store_hit !== expect_hit) report_value("store_hit", expect_hit, store_hit);
    @(posedge clock);
    store_search_en <= 1'b0;
  endtask

  // wait for the drain
  // stores alone never show up as a fill
  task automatic wait_empty(input logic no_fill);
    int n;
    n = 0;
    @(negedge clock);
    while (!mshr_empty && n < TIMEOUT) begin
      if (no_fill && mem_wr) report_fault("mem_wr raised for a store entry");
      @(negedge clock);
      n++;
    end
    if (!mshr_empty) report_fault("timed out waiting for mshr_empty");
  endtask

  task automatic test_reset();
    start_test("reset");
    @(negedge clock);
    if (mshr_ready !== 1'b1) report_value("mshr_ready", 1, mshr_ready);
    if (mshr_empty !== 1'b1) report_value("mshr_empty", 1, mshr_empty);
    if (proc2mem_command !== BUS_NONE) report_value("proc2mem_command", BUS_NONE, proc2mem_command);
    if (mem_wr !== 1'b0) report_value("mem_wr", 0, mem_wr);
    if (store_hit !== 1'b0) report_value("store_hit", 0, store_hit);
    finish_test();
  endtask

  task automatic test_single_load();
    logic [ADDR_W-1:0] addr;
    logic [LINE_W-1:0] fill;
    start_test("single_load");
    addr = $urandom;
    fill = {$urandom, $urandom};
    allocate(3'b001, {3{addr}}, '0, BUS_LOAD, '0);
    accept_request(4'd1, BUS_LOAD, addr, '0, 1'b0);
    @(negedge clock);
    // load in flight and nothing to fill yet
    if (mem_wr !== 1'b0) report_value("mem_wr before reply", 0, mem_wr);
    send_reply(4'd1, fill);
    take_fill(addr, fill, 1'b0);
    @(negedge clock);
    if (mshr_empty !== 1'b1) report_value("mshr_empty after fill", 1, mshr_empty);
    finish_test();
  endtask

  task automatic test_packing();
    logic [MISS_PORTS-1:0][ADDR_W-1:0] addr_a;
    logic [MISS_PORTS-1:0][ADDR_W-1:0] addr_b;
    logic [MISS_PORTS-1:0][LINE_W-1:0] data_a;
    logic [MISS_PORTS-1:0][LINE_W-1:0] data_b;
    start_test("packing");
    for (int p = 0; p < MISS_PORTS; p++) begin
      addr_a[p] = $urandom;
      addr_b[p] = $urandom;
      data_a[p] = {$urandom, $urandom};
      data_b[p] = {$urandom, $urandom};
    end
    // stores retire on acceptance without replies
    allocate(3'b101, addr_a, data_a, BUS_STORE, '0);
    allocate(3'b111, addr_b, data_b, BUS_STORE, '0);
    accept_request(4'd1, BUS_STORE, addr_a[0], data_a[0], 1'b1);
    accept_request(4'd2, BUS_STORE, addr_a[2], data_a[2], 1'b1);
    for (int p = 0; p < MISS_PORTS; p++) begin
      accept_request(TAG_W'(p + 3), BUS_STORE, addr_b[p], data_b[p], 1'b1);
    end
    wait_empty(1'b1);
    finish_test();
  endtask

  task automatic test_out_of_order();
    logic [MISS_PORTS-1:0][ADDR_W-1:0] addr;
    logic [MISS_PORTS-1:0][LINE_W-1:0] fill;
    logic [LINE_W-1:0]                 store_data;
    start_test("out_of_order");
    for (int p = 0; p < MISS_PORTS; p++) begin
      addr[p] = $urandom;
      fill[p] = {$urandom, $urandom};
    end
    store_data = {$urandom, $urandom};
    allocate(3'b111, addr, '0, BUS_LOAD, 3'b100);
    for (int p = 0; p < MISS_PORTS; p++) begin
      accept_request(TAG_W'(p + 1), BUS_LOAD, addr[p], '0, 1'b0);
    end
    // newest replies first
    send_reply(4'd3, fill[2]);
    send_reply(4'd2, fill[1]);
    @(negedge clock);
    // oldest load still out so fills are held back
    if (mem_wr !== 1'b0) report_value("mem_wr before oldest reply", 0, mem_wr);
    store_lookup(addr[2], store_data, 1'b1);
    send_reply(4'd1, fill[0]);
    take_fill(addr[0], fill[0], 1'b0);
    take_fill(addr[1], fill[1], 1'b0);
    // merged line carries the store data and is dirty
    take_fill(addr[2], store_data, 1'b1);
    @(negedge clock);
    if (mshr_empty !== 1'b1) report_value("mshr_empty after fills", 1, mshr_empty);
    finish_test();
  endtask

  task automatic test_store_merge();
    logic [ADDR_W-1:0] addr;
    logic [LINE_W-1:0] old_data;
    logic [LINE_W-1:0] new_data;
    start_test("store_merge");
    addr     = $urandom;
    old_data = {$urandom, $urandom};
    new_data = {$urandom, $urandom};
    allocate(3'b001, {3{addr}}, {3{old_data}}, BUS_STORE, '0);
    // memory silent and the entry still waiting
    store_lookup(addr, new_data, 1'b1);
    accept_request(4'd1, BUS_STORE, addr, new_data, 1'b1);
    wait_empty(1'b1);
    finish_test();
  endtask

  task automatic test_full();
    logic [ADDR_W-1:0] addr [6];
    logic [LINE_W-1:0] fill [6];
    start_test("full");
    for (int k = 0; k < 6; k++) begin
      addr[k] = $urandom;
      fill[k] = {$urandom, $urandom};
    end
    // response stays 0 so every entry stays put
    for (int k = 0; k < 6; k++) begin
      allocate(3'b001, {3{addr[k]}}, '0, BUS_LOAD, '0);
      @(negedge clock);
      if (mshr_ready !== 1'(k < 5)) report_value("mshr_ready", 1'(k < 5), mshr_ready);
    end
    accept_request(4'd1, BUS_LOAD, addr[0], '0, 1'b0);
    @(negedge clock);
    // issued but not retired so still no room
    if (mshr_ready !== 1'b0) report_value("mshr_ready after issue", 0, mshr_ready);
    send_reply(4'd1, fill[0]);
    take_fill(addr[0], fill[0], 1'b0);
    @(negedge clock);
    if (mshr_ready !== 1'b1) report_value("mshr_ready after retire", 1, mshr_ready);
    for (int k = 1; k < 6; k++) begin
      accept_request(TAG_W'(k + 1), BUS_LOAD, addr[k], '0, 1'b0);
    end
    for (int k = 1; k < 6; k++) begin
      send_reply(TAG_W'(k + 1), fill[k]);
    end
    for (int k = 1; k < 6; k++) begin
      take_fill(addr[k], fill[k], 1'b0);
    end
    @(negedge clock);
    if (mshr_empty !== 1'b1) report_value("mshr_empty after drain", 1, mshr_empty);
    finish_test();
  endtask

  initial begin
    void'($urandom(32'haf52));
    error_count       = 0;
    tests_run         = 0;
    tests_failed      = 0;
    reset             = 1'b1;
    miss_en           = '0;
    miss_addr         = '0;
    miss_data         = '0;
    miss_dirty        = '0;
    for (int p = 0; p < MISS_PORTS; p++) begin
      miss_cmd[p] = BUS_NONE;
    end
    store_search_en   = 1'b0;
    store_search_addr = '0;
    store_search_data = '0;
    mem2proc_response = '0;
    mem2proc_tag      = '0;
    mem2proc_data     = '0;
    stored_mem_wr     = 1'b0;
    repeat (5) @(posedge clock);
    reset <= 1'b0;
    test_reset();
    test_single_load();
    test_packing();
    test_out_of_order();
    test_store_merge();
    test_full();
    $display("tests run %0d, failed %0d, errors %0d, assertion failures %0d",
             tests_run, tests_failed, error_count, i_dut.i_chk.fail_count);
    if (error_count == 0 && i_dut.i_chk.fail_count == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

/* flist.f */
design/mshr_pkg.sv
design/mshr_alloc.sv
design/mshr_entries.sv
design/mshr_issue.sv
design/mshr_retire.sv
design/mshr_search.sv
design/mshr_top.sv
sim/tb_clock.sv
sim/mshr_chk.sv
sim/mshr_tb.sv

/* Bender.yml */
package:
  name: mshr

sources:
  - design/mshr_pkg.sv
  - design/mshr_alloc.sv
  - design/mshr_entries.sv
  - design/mshr_issue.sv
  - design/mshr_retire.sv
  - design/mshr_search.sv
  - design/mshr_top.sv
  - target: test
    files:
      - sim/tb_clock.sv
      - sim/mshr_chk.sv
      - sim/mshr_tb.sv
